/* src/trace_cfg.svh */
/*
 * sizing of the instruction trace unit
 * TRACE_DEPTH must be at least 5 and must fit in TRACE_ID_W bits
 */
`ifndef TRACE_CFG_SVH
`define TRACE_CFG_SVH

// id slots, one per instruction that can be in flight
`define TRACE_DEPTH 8
// id width, enough to index TRACE_DEPTH slots
`define TRACE_ID_W 3

// cycle counter and stamps, free running and wrapping
`define CYCLE_W 16

// instruction word as fetched by the CPU
`define INSTR_W 32

// decode stall count, saturates at all ones
`define STALL_W 8

`endif

/* src/trace_pkg.sv */
/*
 * scalar types shared by the trace unit
 * widths come from trace_cfg.svh
 */
`include "trace_cfg.svh"

package trace_pkg;

    //////////////////////////////////////////////////
    // trace record fields
    //////////////////////////////////////////////////

    // instruction id, issued modulo TRACE_DEPTH
    typedef logic [`TRACE_ID_W-1:0] trace_id_t;

    // cycle counter value and fetch/wb stamps
    typedef logic [`CYCLE_W-1:0] cycle_t;

    // raw instruction word
    typedef logic [`INSTR_W-1:0] instr_t;

    // decode stall count per instruction
    typedef logic [`STALL_W-1:0] stall_cnt_t;

    //////////////////////////////////////////////////
    // flush bookkeeping
    //////////////////////////////////////////////////

    // valid tags killed by one flush, fetch and decode only so 0..2
    typedef logic [1:0] kill_cnt_t;

endpackage

/* src/trace_ram.sv */
/*
 * register array, synchronous write, combinational read
 * no reset, rows are valid only after a write
 */
`timescale 1ns/1ps

module trace_ram #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 8
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  payload_t                 wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output payload_t                 rdata
);

    // one row per id slot
    payload_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read port sees the row as stored before this edge
    assign rdata = mem[raddr];

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // a write must hit a defined row inside the array
    a_waddr_known: assert property (@(posedge clk)
        we |-> !$isunknown(waddr) && int'(waddr) < DEPTH);

endmodule

/* src/stage_tracker.sv */
/*
 * follows valid/id tags through fetch, decode, execute, memory, write-back
 * flush wins over stall; memory and write-back never hold
 */
`timescale 1ns/1ps
`include "trace_cfg.svh"

module stage_tracker
    import trace_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      stall,
    input  logic      flush,
    output logic      fetch_capture,
    output trace_id_t fetch_id,
    output logic      dec_valid,
    output trace_id_t dec_id,
    output logic      hold,
    output logic      wb_valid,
    output trace_id_t wb_id,
    output cycle_t    cycle_count,
    output kill_cnt_t kill_count
);

    localparam int STAGES = 5;
    // stage slots in the tag arrays
    localparam int S_FE = 0;
    localparam int S_DE = 1;
    localparam int S_EX = 2;
    localparam int S_ME = 3;
    localparam int S_WB = 4;

    logic [STAGES-1:0] tag_valid;
    trace_id_t         tag_id [STAGES];
    trace_id_t         next_id;
    cycle_t            cycle_cnt;
    logic              capture;
    logic              dup_valid_id;

    // a new word enters fetch only on a free edge after reset
    assign capture = !rst && !stall && !flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_cnt <= '0;
            next_id   <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + cycle_t'(1);
            if (capture) begin
                // ids wrap at TRACE_DEPTH, not at the id width
                if (next_id == trace_id_t'(`TRACE_DEPTH - 1))
                    next_id <= '0;
                else
                    next_id <= next_id + trace_id_t'(1);
            end
        end
    end

    //////////////////////////////////////////////////
    // tag pipeline
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            tag_valid <= '0;
            // stale ids look like the last id before 0, so they never alias next_id
            for (int i = 0; i < STAGES; i++) begin
                tag_id[i] <= trace_id_t'(`TRACE_DEPTH - 1);
            end
        end else begin
            // tail of the pipe always moves
            tag_valid[S_WB] <= tag_valid[S_ME];
            tag_id[S_WB]    <= tag_id[S_ME];
            tag_valid[S_ME] <= tag_valid[S_EX];
            tag_id[S_ME]    <= tag_id[S_EX];
            // execute id follows decode and bubbles carry a stale copy
            tag_id[S_EX]    <= tag_id[S_DE];
            if (flush) begin
                tag_valid[S_FE] <= 1'b0;
                tag_valid[S_DE] <= 1'b0;
                tag_valid[S_EX] <= 1'b0;
            end else if (stall) begin
                // fetch and decode hold while execute gets a bubble
                tag_valid[S_EX] <= 1'b0;
            end else begin
                tag_valid[S_FE] <= 1'b1;
                tag_id[S_FE]    <= next_id;
                tag_valid[S_DE] <= tag_valid[S_FE];
                tag_id[S_DE]    <= tag_id[S_FE];
                tag_valid[S_EX] <= tag_valid[S_DE];
            end
        end
    end

    assign fetch_capture = capture;
    assign fetch_id      = next_id;
    assign dec_valid     = tag_valid[S_DE];
    assign dec_id        = tag_id[S_DE];
    assign hold          = stall && !flush;
    assign wb_valid      = tag_valid[S_WB];
    assign wb_id         = tag_id[S_WB];
    assign cycle_count   = cycle_cnt;
    // only fetch and decode can be killed
    assign kill_count    = flush ? kill_cnt_t'(tag_valid[S_FE]) + kill_cnt_t'(tag_valid[S_DE])
                                 : '0;

    // two valid stages sharing an id would mix up table rows
    always_comb begin
        dup_valid_id = 1'b0;
        for (int i = 0; i < STAGES; i++) begin
            for (int j = i + 1; j < STAGES; j++) begin
                if (tag_valid[i] && tag_valid[j] && tag_id[i] == tag_id[j])
                    dup_valid_id = 1'b1;
            end
        end
    end

    a_ids_distinct: assert property (@(posedge clk) disable iff (rst)
        !dup_valid_id);

    a_valid_known: assert property (@(posedge clk) disable iff (rst)
        (flush || stall) |=> !$isunknown(tag_valid));

endmodule

/* src/trace_table.sv */
/*
 * per-id store of instruction word, fetch stamp and decode stall count
 * rows are read at write-back; the stamp is the cycle spent in fetch
 */
`timescale 1ns/1ps
`include "trace_cfg.svh"

module trace_table
    import trace_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       fetch_capture,
    input  logic       dec_valid,
    input  logic       hold,
    input  instr_t     fetch_word,
    input  trace_id_t  fetch_id,
    input  trace_id_t  dec_id,
    input  trace_id_t  wb_id,
    input  cycle_t     cycle_count,
    output instr_t     wb_instr,
    output cycle_t     wb_fetch_cycle,
    output stall_cnt_t wb_stall_cycles
);

    stall_cnt_t stall_cnt [`TRACE_DEPTH];
    cycle_t     fetch_stamp;

    // after the capture edge the counter already shows the fetch cycle
    assign fetch_stamp = cycle_count + cycle_t'(1);

    //////////////////////////////////////////////////
    // word and stamp arrays
    //////////////////////////////////////////////////

    trace_ram #(
        .payload_t (instr_t),
        .DEPTH     (`TRACE_DEPTH)
    ) i_instr_ram (
        .clk   (clk),
        .we    (fetch_capture),
        .waddr (fetch_id),
        .wdata (fetch_word),
        .raddr (wb_id),
        .rdata (wb_instr)
    );

    trace_ram #(
        .payload_t (cycle_t),
        .DEPTH     (`TRACE_DEPTH)
    ) i_stamp_ram (
        .clk   (clk),
        .we    (fetch_capture),
        .waddr (fetch_id),
        .wdata (fetch_stamp),
        .raddr (wb_id),
        .rdata (wb_fetch_cycle)
    );

    //////////////////////////////////////////////////
    // decode stall counters
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `TRACE_DEPTH; i++) begin
                stall_cnt[i] <= '0;
            end
        end else begin
            // hold excludes capture, so both never hit on one edge
            if (hold && dec_valid && stall_cnt[dec_id] != '1)
                stall_cnt[dec_id] <= stall_cnt[dec_id] + stall_cnt_t'(1);
            // fresh instruction starts with no stalls
            if (fetch_capture)
                stall_cnt[fetch_id] <= '0;
        end
    end

    assign wb_stall_cycles = stall_cnt[wb_id];

    // tracker keeps stale ids behind next id, so wb row is never reused early
    a_no_wb_overwrite: assert property (@(posedge clk) disable iff (rst)
        fetch_capture |-> fetch_id != wb_id);

endmodule

/* src/retire_reporter.sv */
/*
 * one record per retired instruction, one cycle after write-back
 * no back-pressure; counts are 16 bits and wrap
 */
`timescale 1ns/1ps

module retire_reporter
    import trace_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_valid,
    input  trace_id_t   wb_id,
    input  instr_t      wb_instr,
    input  cycle_t      wb_fetch_cycle,
    input  cycle_t      cycle_count,
    input  stall_cnt_t  wb_stall_cycles,
    input  kill_cnt_t   kill_count,
    output logic        rec_valid,
    output trace_id_t   rec_id,
    output instr_t      rec_instr,
    output cycle_t      rec_fetch_cycle,
    output cycle_t      rec_wb_cycle,
    output stall_cnt_t  rec_stall_cycles,
    output logic [15:0] retired_count,
    output logic [15:0] flushed_count
);

    //////////////////////////////////////////////////
    // strobe and running counts
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rec_valid     <= 1'b0;
            retired_count <= '0;
            flushed_count <= '0;
        end else begin
            rec_valid <= wb_valid;
            if (wb_valid)
                retired_count <= retired_count + 16'd1;
            // kill_count is zero on edges without flush
            flushed_count <= flushed_count + {14'd0, kill_count};
        end
    end

    // record payload, only loaded on retire
    always_ff @(posedge clk) begin
        if (wb_valid) begin
            rec_id           <= wb_id;
            rec_instr        <= wb_instr;
            rec_fetch_cycle  <= wb_fetch_cycle;
            rec_wb_cycle     <= cycle_count;
            rec_stall_cycles <= wb_stall_cycles;
        end
    end

    // four stage moves at least, plus one per counted decode stall
    a_latency_floor: assert property (@(posedge clk) disable iff (rst)
        rec_valid |-> cycle_t'(rec_wb_cycle - rec_fetch_cycle)
                      >= cycle_t'(rec_stall_cycles) + cycle_t'(4));

endmodule

/* src/pipe_trace_top.sv */
/*
 * instruction trace unit for a five-stage in-order pipeline
 * stall is a level, flush a one-cycle pulse; records must be taken on rec_valid
 */
`timescale 1ns/1ps

module pipe_trace_top
    import trace_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  instr_t      fetch_word,
    input  logic        stall,
    input  logic        flush,
    output logic        rec_valid,
    output trace_id_t   rec_id,
    output instr_t      rec_instr,
    output cycle_t      rec_fetch_cycle,
    output cycle_t      rec_wb_cycle,
    output stall_cnt_t  rec_stall_cycles,
    output logic [15:0] retired_count,
    output logic [15:0] flushed_count
);

    // tracker to table
    logic       fetch_capture;
    trace_id_t  fetch_id;
    logic       dec_valid;
    trace_id_t  dec_id;
    logic       hold;
    // tracker to table and reporter
    logic       wb_valid;
    trace_id_t  wb_id;
    cycle_t     cycle_count;
    kill_cnt_t  kill_count;
    // write-back row
    instr_t     wb_instr;
    cycle_t     wb_fetch_cycle;
    stall_cnt_t wb_stall_cycles;

    stage_tracker i_stage_tracker (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .flush         (flush),
        .fetch_capture (fetch_capture),
        .fetch_id      (fetch_id),
        .dec_valid     (dec_valid),
        .dec_id        (dec_id),
        .hold          (hold),
        .wb_valid      (wb_valid),
        .wb_id         (wb_id),
        .cycle_count   (cycle_count),
        .kill_count    (kill_count)
    );

    trace_table i_trace_table (
        .clk             (clk),
        .rst             (rst),
        .fetch_capture   (fetch_capture),
        .dec_valid       (dec_valid),
        .hold            (hold),
        .fetch_word      (fetch_word),
        .fetch_id        (fetch_id),
        .dec_id          (dec_id),
        .wb_id           (wb_id),
        .cycle_count     (cycle_count),
        .wb_instr        (wb_instr),
        .wb_fetch_cycle  (wb_fetch_cycle),
        .wb_stall_cycles (wb_stall_cycles)
    );

    retire_reporter i_retire_reporter (
        .clk              (clk),
        .rst              (rst),
        .wb_valid         (wb_valid),
        .wb_id            (wb_id),
        .wb_instr         (wb_instr),
        .wb_fetch_cycle   (wb_fetch_cycle),
        .cycle_count      (cycle_count),
        .wb_stall_cycles  (wb_stall_cycles),
        .kill_count       (kill_count),
        .rec_valid        (rec_valid),
        .rec_id           (rec_id),
        .rec_instr        (rec_instr),
        .rec_fetch_cycle  (rec_fetch_cycle),
        .rec_wb_cycle     (rec_wb_cycle),
        .rec_stall_cycles (rec_stall_cycles),
        .retired_count    (retired_count),
        .flushed_count    (flushed_count)
    );

endmodule

/* verification/pipe_trace_model.svh */
/*
 * reference pipeline model and LFSR, included inside the testbench module
 * needs ID_SLOTS and STALL_MAX from the including module
 */
`ifndef PIPE_TRACE_MODEL_SVH
`define PIPE_TRACE_MODEL_SVH

// model slots: 0 fetch, 1 decode, 2 execute, 3 memory, 4 write-back
logic        m_valid  [5];
trace_id_t   m_id     [5];
instr_t      m_word   [5];
cycle_t      m_stamp  [5];
stall_cnt_t  m_stalls [5];
trace_id_t   m_next_id;
// cycle count seen by the DUT in the current cycle
cycle_t      m_cycle;
logic [15:0] m_retired;
logic [15:0] m_flushed;
logic [31:0] lfsr_state;

// outputs the DUT should show after the coming rising edge
logic        nxt_valid;
trace_id_t   nxt_id;
instr_t      nxt_instr;
cycle_t      nxt_fetch_cycle;
cycle_t      nxt_wb_cycle;
stall_cnt_t  nxt_stalls;
logic [15:0] nxt_retired;
logic [15:0] nxt_flushed;

//////////////////////////////////////////////////
// random source
//////////////////////////////////////////////////

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

// one lfsr step per bit taken
task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
endtask

//////////////////////////////////////////////////
// pipeline model
//////////////////////////////////////////////////

task automatic model_reset();
    for (int i = 0; i < 5; i++) begin
        m_valid[i]  = 1'b0;
        m_id[i]     = '0;
        m_word[i]   = '0;
        m_stamp[i]  = '0;
        m_stalls[i] = '0;
    end
    m_next_id   = '0;
    m_cycle     = '0;
    m_retired   = '0;
    m_flushed   = '0;
    nxt_valid   = 1'b0;
    nxt_retired = '0;
    nxt_flushed = '0;
endtask

task automatic copy_slot(input int dst, input int src);
    m_valid[dst]  = m_valid[src];
    m_id[dst]     = m_id[src];
    m_word[dst]   = m_word[src];
    m_stamp[dst]  = m_stamp[src];
    m_stalls[dst] = m_stalls[src];
endtask

// applies the stage rules of one rising edge
task automatic model_step(input logic st, input logic fl, input instr_t word);
    int kills;
    // write-back slot becomes the record after this edge
    nxt_valid       = m_valid[4];
    nxt_id          = m_id[4];
    nxt_instr       = m_word[4];
    nxt_fetch_cycle = m_stamp[4];
    nxt_wb_cycle    = m_cycle;
    nxt_stalls      = m_stalls[4];
    if (m_valid[4])
        m_retired = m_retired + 16'd1;
    // memory and write-back never hold
    copy_slot(4, 3);
    copy_slot(3, 2);
    if (fl) begin
        kills = int'(m_valid[0]) + int'(m_valid[1]);
        m_flushed  = m_flushed + 16'(kills);
        m_valid[0] = 1'b0;
        m_valid[1] = 1'b0;
        m_valid[2] = 1'b0;
    end else if (st) begin
        if (m_valid[1] && m_stalls[1] != stall_cnt_t'(STALL_MAX))
            m_stalls[1] = m_stalls[1] + stall_cnt_t'(1);
        m_valid[2] = 1'b0;
    end else begin
        copy_slot(2, 1);
        copy_slot(1, 0);
        m_valid[0]  = 1'b1;
        m_id[0]     = m_next_id;
        m_word[0]   = word;
        // stamp is the cycle the word sits in fetch
        m_stamp[0]  = m_cycle + cycle_t'(1);
        m_stalls[0] = '0;
        m_next_id   = trace_id_t'((int'(m_next_id) + 1) % ID_SLOTS);
    end
    m_cycle     = m_cycle + cycle_t'(1);
    nxt_retired = m_retired;
    nxt_flushed = m_flushed;
endtask

`endif

/* verification/pipe_trace_tb.sv */
/*
 * testbench for pipe_trace_top, plays the CPU with lfsr driven stall and flush
 * records are checked by assertions on the falling edge against a model
 */
`timescale 1ns/1ps

module pipe_trace_tb
    import trace_pkg::*;
();

    localparam int ID_SLOTS     = 8;
    localparam int STALL_MAX    = 255;
    localparam int RESET_CYCLES = 16;
    localparam int P1_CYCLES    = 100;
    localparam int P2_CYCLES    = 250;
    localparam int P3_CYCLES    = 250;
    localparam int P4_CYCLES    = 350;
    // a drain needs at most four held edges
    localparam int DRAIN_MAX    = 8;
    localparam int TAIL_CYCLES  = 2;
    localparam int RUN_CYCLES   = RESET_CYCLES + P1_CYCLES + P2_CYCLES + P3_CYCLES
                                  + P4_CYCLES + 4 * DRAIN_MAX + TAIL_CYCLES;
    localparam int TIMEOUT_CYCLES = 2 * RUN_CYCLES;

    logic        clk;
    logic        rst;
    instr_t      fetch_word;
    logic        stall;
    logic        flush;
    logic        rec_valid;
    trace_id_t   rec_id;
    instr_t      rec_instr;
    cycle_t      rec_fetch_cycle;
    cycle_t      rec_wb_cycle;
    stall_cnt_t  rec_stall_cycles;
    logic [15:0] retired_count;
    logic [15:0] flushed_count;

    // expected outputs for the current cycle
    logic        exp_valid;
    trace_id_t   exp_id;
    instr_t      exp_instr;
    cycle_t      exp_fetch_cycle;
    cycle_t      exp_wb_cycle;
    stall_cnt_t  exp_stalls;
    logic [15:0] exp_retired;
    logic [15:0] exp_flushed;
    logic [15:0] strobes_seen;
    logic        free_phase;
    int          error_count;

    `include "pipe_trace_model.svh"

    pipe_trace_top i_pipe_trace_top (
        .clk              (clk),
        .rst              (rst),
        .fetch_word       (fetch_word),
        .stall            (stall),
        .flush            (flush),
        .rec_valid        (rec_valid),
        .rec_id           (rec_id),
        .rec_instr        (rec_instr),
        .rec_fetch_cycle  (rec_fetch_cycle),
        .rec_wb_cycle     (rec_wb_cycle),
        .rec_stall_cycles (rec_stall_cycles),
        .retired_count    (retired_count),
        .flushed_count    (flushed_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // model prediction turns into expectation at the edge it predicts
    always @(posedge clk) begin
        if (rst) begin
            exp_valid    <= 1'b0;
            exp_retired  <= '0;
            exp_flushed  <= '0;
            strobes_seen <= '0;
        end else begin
            exp_valid       <= nxt_valid;
            exp_id          <= nxt_id;
            exp_instr       <= nxt_instr;
            exp_fetch_cycle <= nxt_fetch_cycle;
            exp_wb_cycle    <= nxt_wb_cycle;
            exp_stalls      <= nxt_stalls;
            exp_retired     <= nxt_retired;
            exp_flushed     <= nxt_flushed;
            if (rec_valid)
                strobes_seen <= strobes_seen + 16'd1;
        end
    end

    task automatic note_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] want);
        $display("** Error at %0d ns: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
        error_count++;
    endtask

    //////////////////////////////////////////////////
    // checks sampled on the falling edge
    //////////////////////////////////////////////////

    a_rec_valid: assert property (@(negedge clk) disable iff (rst) rec_valid == exp_valid)
        else note_mismatch("rec_valid", 64'(rec_valid), 64'(exp_valid));
    a_rec_id: assert property (@(negedge clk) disable iff (rst) exp_valid |-> rec_id == exp_id)
        else note_mismatch("rec_id", 64'(rec_id), 64'(exp_id));
    a_rec_instr: assert property (@(negedge clk) disable iff (rst)
        exp_valid |-> rec_instr == exp_instr)
        else note_mismatch("rec_instr", 64'(rec_instr), 64'(exp_instr));
    a_rec_fetch: assert property (@(negedge clk) disable iff (rst)
        exp_valid |-> rec_fetch_cycle == exp_fetch_cycle)
        else note_mismatch("rec_fetch_cycle", 64'(rec_fetch_cycle), 64'(exp_fetch_cycle));
    a_rec_wb: assert property (@(negedge clk) disable iff (rst)
        exp_valid |-> rec_wb_cycle == exp_wb_cycle)
        else note_mismatch("rec_wb_cycle", 64'(rec_wb_cycle), 64'(exp_wb_cycle));
    a_rec_stalls: assert property (@(negedge clk) disable iff (rst)
        exp_valid |-> rec_stall_cycles == exp_stalls)
        else note_mismatch("rec_stall_cycles", 64'(rec_stall_cycles), 64'(exp_stalls));
    a_retired: assert property (@(negedge clk) disable iff (rst) retired_count == exp_retired)
        else note_mismatch("retired_count", 64'(retired_count), 64'(exp_retired));
    a_flushed: assert property (@(negedge clk) disable iff (rst) flushed_count == exp_flushed)
        else note_mismatch("flushed_count", 64'(flushed_count), 64'(exp_flushed));
    // count includes the strobe showing right now
    a_strobes: assert property (@(negedge clk) disable iff (rst)
        retired_count == strobes_seen + 16'(rec_valid))
        else note_mismatch("retired_count", 64'(retired_count),
                           64'(strobes_seen + 16'(rec_valid)));
    // free-running pipe has fixed latency
    a_free_stalls: assert property (@(negedge clk) disable iff (rst)
        free_phase && rec_valid |-> rec_stall_cycles == '0)
        else note_mismatch("rec_stall_cycles", 64'(rec_stall_cycles), 64'd0);
    a_free_latency: assert property (@(negedge clk) disable iff (rst)
        free_phase && rec_valid |-> rec_wb_cycle == rec_fetch_cycle + cycle_t'(4))
        else note_mismatch("rec_wb_cycle", 64'(rec_wb_cycle),
                           64'(rec_fetch_cycle + cycle_t'(4)));

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    // called at a falling edge, returns at the next one
    task automatic drive_cycle(input logic st, input logic fl);
        logic [31:0] w;
        draw_bits(32, w);
        fetch_word = w;
        stall      = st;
        flush      = fl;
        model_step(st, fl, w);
        @(negedge clk);
    endtask

    // hold fetch and decode until every record behind them is out
    task automatic drain_pipe();
        while (m_valid[2] || m_valid[3] || m_valid[4] || retired_count != m_retired)
            drive_cycle(1'b1, 1'b0);
    endtask

    // zero bits turns that event off
    task automatic run_phase(input int num, input string name, input int n,
                             input int stall_bits, input int flush_bits);
        int          err_start;
        logic [15:0] rec_start;
        int          burst;
        logic        fl_prev;
        logic        st;
        logic        fl;
        logic [31:0] r;
        err_start = error_count;
        rec_start = m_retired;
        burst     = 0;
        fl_prev   = 1'b0;
        for (int i = 0; i < n; i++) begin
            draw_bits(stall_bits, r);
            // bursts of 1 to 4 stall cycles
            if (burst == 0 && stall_bits > 0 && r == 0) begin
                draw_bits(2, r);
                burst = int'(r) + 1;
            end
            draw_bits(flush_bits, r);
            // flush is a pulse and never comes twice in a row
            fl = flush_bits > 0 && r == 0 && !fl_prev;
            st = burst > 0;
            if (burst > 0)
                burst--;
            drive_cycle(st, fl);
            fl_prev = fl;
        end
        drain_pipe();
        $display("phase %0d %s: %0d records, %0d errors", num, name,
                 m_retired - rec_start, error_count - err_start);
    endtask

    initial begin
        rst         = 1'b1;
        stall       = 1'b0;
        flush       = 1'b0;
        fetch_word  = '0;
        free_phase  = 1'b0;
        error_count = 0;
        lfsr_state  = 32'h36296098;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        free_phase = 1'b1;
        run_phase(1, "free running", P1_CYCLES, 0, 0);
        free_phase = 1'b0;
        run_phase(2, "stall bursts", P2_CYCLES, 2, 0);
        run_phase(3, "flushes", P3_CYCLES, 3, 3);
        run_phase(4, "mixed with id wrap", P4_CYCLES, 2, 4);
        // let the last strobe be checked
        repeat (TAIL_CYCLES) drive_cycle(1'b1, 1'b0);

        $display("total: %0d records, %0d flushed, %0d errors",
                 m_retired, m_flushed, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // hang guard at twice the nominal run length
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the DUT never caught up with the model", cycles);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* build.f */
+incdir+src
+incdir+verification
src/trace_pkg.sv
src/trace_ram.sv
src/stage_tracker.sv
src/trace_table.sv
src/retire_reporter.sv
src/pipe_trace_top.sv
verification/pipe_trace_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the pipe trace testbench with Verilator and runs it
# exit status is 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f \
    --top-module pipe_trace_tb -Mdir obj_dir -o pipe_trace_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/pipe_trace_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
